/* core_pkg.sv */
`default_nettype none

package core_pkg;

  localparam int data_w = 32;
  localparam int cmd_w = 32;
  localparam int op_w = 4;

  typedef logic [data_w-1:0] data_t;  // one RAM / ALU word
  typedef logic [cmd_w-1:0] cmd_t;    // op | dst | src0 | src1 | spare
  typedef logic [op_w-1:0] op_code_t;

  // command word field positions
  localparam int cmd_addr_w = 8;   // each address field
  localparam int cmd_op_lsb = 28;  // bits 31:28
  localparam int cmd_dst_lsb = 20; // bits 27:20
  localparam int cmd_src0_lsb = 12;
  localparam int cmd_src1_lsb = 4; // bits 3:0 spare

  // op codes, 10..15 undefined and give zero
  localparam op_code_t op_mov = 4'd0;
  localparam op_code_t op_add = 4'd1;
  localparam op_code_t op_sub = 4'd2;
  localparam op_code_t op_mul = 4'd3;
  localparam op_code_t op_div = 4'd4;
  localparam op_code_t op_shr = 4'd5;
  localparam op_code_t op_shl = 4'd6;
  localparam op_code_t op_xor = 4'd7;
  localparam op_code_t op_and = 4'd8;
  localparam op_code_t op_or = 4'd9;

  // sequencer -> alu step
  typedef enum logic [1:0] {
    alu_idle,
    alu_begin,
    alu_results
  } alu_state_t;

  typedef enum logic [2:0] {
    s_idle,
    s_rd0,   // fetch src0
    s_rd1,   // fetch src1
    s_exec,  // alu running
    s_wr_lo,
    s_wr_hi
  } seq_state_t;

endpackage

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

  localparam int addr_w = 8;
  localparam int mem_depth = 256; // full 8-bit space

  typedef logic [addr_w-1:0] addr_t;

  // who owned the ram read port last cycle
  localparam logic client_host = 1'b0;
  localparam logic client_core = 1'b1;

endpackage

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram (
  input  wire                clk,
  input  wire logic          we,
  input  mem_pkg::addr_t     addr,
  input  core_pkg::data_t    wdata,
  output core_pkg::data_t    rdata
);

  // no reset, contents undefined after power up
  core_pkg::data_t mem [mem_pkg::mem_depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;  // visible to a read issued next cycle
    end
    // registered read, old data on a same-cycle write
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  wire                clk,
  input  wire                rst,
  // host side, always served first
  input  wire                host_rd,
  input  wire                host_wr,
  input  mem_pkg::addr_t     host_addr,
  input  core_pkg::data_t    host_wdata,
  output core_pkg::data_t    host_rdata,
  output logic               host_rvalid,
  // sequencer side
  input  wire                core_req,
  input  wire                core_we,
  input  mem_pkg::addr_t     core_addr,
  input  core_pkg::data_t    core_wdata,
  output logic               core_gnt,
  output core_pkg::data_t    core_rdata,
  output logic               core_rvalid,
  // ram port
  output logic               ram_we,
  output mem_pkg::addr_t     ram_addr,
  output core_pkg::data_t    ram_wdata,
  input  core_pkg::data_t    ram_rdata
);

  logic host_act;   // any host strobe this cycle
  logic host_rd_go; // host read, write wins if both strobed
  logic core_rd_go;
  logic rd_pend;    // a read was issued last cycle
  logic rd_client;  // and by whom

  assign host_act = host_rd | host_wr;
  assign host_rd_go = host_rd & ~host_wr;
  assign core_gnt = core_req & ~host_act; // host strobe is the back-pressure
  assign core_rd_go = core_gnt & ~core_we;

  // ram port mux, host first
  assign ram_we = host_act ? host_wr : (core_gnt & core_we);
  assign ram_addr = host_act ? host_addr : core_addr;
  assign ram_wdata = host_act ? host_wdata : core_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
      rd_client <= mem_pkg::client_host;
    end else begin
      rd_pend <= host_rd_go | core_rd_go;
      if (host_act) rd_client <= mem_pkg::client_host;
      else if (core_gnt) rd_client <= mem_pkg::client_core;
    end
  end

  // steer returning data, one valid per read
  assign host_rvalid = rd_pend & (rd_client == mem_pkg::client_host);
  assign core_rvalid = rd_pend & (rd_client == mem_pkg::client_core);
  assign host_rdata = (rd_client == mem_pkg::client_host) ? ram_rdata : '0;
  assign core_rdata = (rd_client == mem_pkg::client_core) ? ram_rdata : '0;

endmodule

`default_nettype wire

/* serial_divider.sv */
`timescale 1ns/1ns
`default_nettype none

module serial_divider (
  input  wire                clk,
  input  wire                rst,
  input  wire                start,
  input  core_pkg::data_t    dividend,
  input  core_pkg::data_t    divisor,
  output core_pkg::data_t    quotient,
  output core_pkg::data_t    remainder,
  output logic               done
);

  logic [5:0] step_cnt;          // steps left, 0 = idle
  core_pkg::data_t rem_r;        // partial remainder
  core_pkg::data_t quot_r;       // dividend shifts out, quotient shifts in
  core_pkg::data_t divisor_r;
  core_pkg::data_t dividend_r;   // kept for the /0 result
  logic [core_pkg::data_w:0] shifted;
  logic [core_pkg::data_w:0] trial;
  logic q_bit;
  logic last_step;

  // one restoring step
  assign shifted = {rem_r, quot_r[core_pkg::data_w-1]};
  assign trial = shifted - {1'b0, divisor_r};
  assign q_bit = ~trial[core_pkg::data_w]; // no borrow -> subtract fits
  assign last_step = (step_cnt == 6'd1);

  // step counter and done pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      step_cnt <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        step_cnt <= 6'd32; // one step per quotient bit
      end else if (step_cnt != 6'd0) begin
        step_cnt <= step_cnt - 6'd1;
        done <= last_step;
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (start) begin
      rem_r <= '0;
      quot_r <= dividend;
      divisor_r <= divisor;
      dividend_r <= dividend;
    end else if (step_cnt != 6'd0) begin
      if (last_step && divisor_r == '0) begin
        quot_r <= '1;          // /0: all ones
        rem_r <= dividend_r;   // and the dividend back
      end else begin
        quot_r <= {quot_r[core_pkg::data_w-2:0], q_bit};
        rem_r <= q_bit ? trial[core_pkg::data_w-1:0] : shifted[core_pkg::data_w-1:0];
      end
    end
  end

  // held until the next start
  assign quotient = quot_r;
  assign remainder = rem_r;

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  wire                   clk,
  input  wire                   rst,
  input  core_pkg::alu_state_t  state,
  input  core_pkg::op_code_t    op,
  input  core_pkg::data_t       src0,
  input  core_pkg::data_t       src1,
  output core_pkg::data_t       dst,
  output core_pkg::data_t       dst_h,
  output logic                  next_state
);

  core_pkg::data_t dst_r;    // low result
  core_pkg::data_t dst_h_r;  // high result / remainder
  core_pkg::data_t shr_res;
  core_pkg::data_t shl_res;
  core_pkg::data_t div_q;
  core_pkg::data_t div_r;
  logic [2*core_pkg::data_w-1:0] sum64;
  logic [2*core_pkg::data_w-1:0] diff64;
  logic [2*core_pkg::data_w-1:0] prod64;
  logic in_begin;
  logic div_start;
  logic div_done;
  logic shift_big;           // shift amount >= word width

  assign in_begin = (state == core_pkg::alu_begin);
  assign div_start = in_begin & (op == core_pkg::op_div);

  // zero-extended so the high word holds carry / borrow
  assign sum64 = {{core_pkg::data_w{1'b0}}, src0} + {{core_pkg::data_w{1'b0}}, src1};
  assign diff64 = {{core_pkg::data_w{1'b0}}, src0} - {{core_pkg::data_w{1'b0}}, src1};
  assign prod64 = src0 * src1; // unsigned 32x32

  assign shift_big = (src1 >= core_pkg::data_t'(core_pkg::data_w));
  assign shr_res = shift_big ? '0 : (src0 >> src1[4:0]);
  assign shl_res = shift_big ? '0 : (src0 << src1[4:0]);

  serial_divider divider_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (div_start),
    .dividend  (src0),
    .divisor   (src1),
    .quotient  (div_q),
    .remainder (div_r),
    .done      (div_done)
  );

  // completion pulse, one cycle after begin or after divider done
  always_ff @(posedge clk) begin
    if (rst) begin
      next_state <= 1'b0;
    end else begin
      next_state <= (in_begin & (op != core_pkg::op_div)) | div_done;
    end
  end

  // results registered on begin, div lands later
  always_ff @(posedge clk) begin
    if (div_done) begin
      dst_r <= div_q;
      dst_h_r <= div_r;
    end else if (in_begin) begin
      dst_h_r <= '0; // most ops have no high word
      case (op)
        core_pkg::op_mov: dst_r <= src0;
        core_pkg::op_add: {dst_h_r, dst_r} <= sum64;
        core_pkg::op_sub: {dst_h_r, dst_r} <= diff64; // high = ones on borrow
        core_pkg::op_mul: {dst_h_r, dst_r} <= prod64;
        core_pkg::op_div: dst_r <= '0;              // wait for divider
        core_pkg::op_shr: dst_r <= shr_res;
        core_pkg::op_shl: dst_r <= shl_res;
        core_pkg::op_xor: dst_r <= src0 ^ src1;
        core_pkg::op_and: dst_r <= src0 & src1;
        core_pkg::op_or: dst_r <= src0 | src1;
        default: dst_r <= '0; // undefined op, still completes
      endcase
    end
  end

  // outputs only valid in the results step
  assign dst = (state == core_pkg::alu_results) ? dst_r : '0;
  assign dst_h = (state == core_pkg::alu_results) ? dst_h_r : '0;

endmodule

`default_nettype wire

/* cmd_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_sequencer (
  input  wire                   clk,
  input  wire                   rst,
  input  core_pkg::cmd_t        cmd,
  input  wire                   cmd_valid,
  output logic                  busy,
  output logic                  cmd_done,
  // ram requests via the arbiter
  output logic                  core_req,
  output logic                  core_we,
  output mem_pkg::addr_t        core_addr,
  output core_pkg::data_t       core_wdata,
  input  wire                   core_gnt,
  input  wire                   core_rvalid,
  input  core_pkg::data_t       core_rdata,
  // alu control
  output core_pkg::alu_state_t  alu_state,
  output core_pkg::op_code_t    alu_op,
  output core_pkg::data_t       alu_src0,
  output core_pkg::data_t       alu_src1,
  input  wire                   alu_next,
  input  core_pkg::data_t       alu_dst,
  input  core_pkg::data_t       alu_dst_h
);

  core_pkg::seq_state_t state;
  core_pkg::cmd_t cmd_r;      // latched command
  core_pkg::data_t src0_r;
  core_pkg::data_t src1_r;
  core_pkg::data_t res_lo;
  core_pkg::data_t res_hi;
  mem_pkg::addr_t dst_addr;
  mem_pkg::addr_t src0_addr;
  mem_pkg::addr_t src1_addr;
  logic wait_rd;              // read granted, data not back yet
  logic in_rd;
  logic in_wr;
  logic rd_back;

  // command fields
  assign alu_op = cmd_r[core_pkg::cmd_op_lsb +: core_pkg::op_w];
  assign dst_addr = cmd_r[core_pkg::cmd_dst_lsb +: core_pkg::cmd_addr_w];
  assign src0_addr = cmd_r[core_pkg::cmd_src0_lsb +: core_pkg::cmd_addr_w];
  assign src1_addr = cmd_r[core_pkg::cmd_src1_lsb +: core_pkg::cmd_addr_w];

  assign in_rd = (state == core_pkg::s_rd0) | (state == core_pkg::s_rd1);
  assign in_wr = (state == core_pkg::s_wr_lo) | (state == core_pkg::s_wr_hi);
  assign rd_back = wait_rd & core_rvalid;

  // request held until granted
  assign core_req = (in_rd & ~wait_rd) | in_wr;
  assign core_we = in_wr;
  always_comb begin
    case (state)
      core_pkg::s_rd1: core_addr = src1_addr;
      core_pkg::s_wr_lo: core_addr = dst_addr;
      core_pkg::s_wr_hi: core_addr = dst_addr + mem_pkg::addr_t'(1); // 255 wraps to 0
      default: core_addr = src0_addr;
    endcase
  end
  assign core_wdata = (state == core_pkg::s_wr_hi) ? res_hi : res_lo;

  assign busy = (state != core_pkg::s_idle); // drops the cycle after cmd_done
  assign cmd_done = (state == core_pkg::s_wr_hi) & core_gnt; // with last write

  assign alu_src0 = src0_r;
  assign alu_src1 = src1_r;

  // control fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= core_pkg::s_idle;
      wait_rd <= 1'b0;
      alu_state <= core_pkg::alu_idle;
    end else begin
      case (state)
        core_pkg::s_idle: begin
          if (cmd_valid) state <= core_pkg::s_rd0;
        end
        core_pkg::s_rd0, core_pkg::s_rd1: begin
          if (!wait_rd && core_gnt) begin
            wait_rd <= 1'b1;
          end else if (rd_back) begin
            wait_rd <= 1'b0;
            if (state == core_pkg::s_rd0) begin
              state <= core_pkg::s_rd1;
            end else begin
              state <= core_pkg::s_exec;
              alu_state <= core_pkg::alu_begin; // single cycle
            end
          end
        end
        core_pkg::s_exec: begin
          if (alu_state == core_pkg::alu_results) begin
            alu_state <= core_pkg::alu_idle;
            state <= core_pkg::s_wr_lo;
          end else if (alu_next) begin
            alu_state <= core_pkg::alu_results;
          end else begin
            alu_state <= core_pkg::alu_idle; // waiting on alu
          end
        end
        core_pkg::s_wr_lo: begin
          if (core_gnt) state <= core_pkg::s_wr_hi;
        end
        core_pkg::s_wr_hi: begin
          if (core_gnt) state <= core_pkg::s_idle;
        end
        default: state <= core_pkg::s_idle;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (state == core_pkg::s_idle && cmd_valid) cmd_r <= cmd;
    if (rd_back && state == core_pkg::s_rd0) src0_r <= core_rdata;
    if (rd_back && state == core_pkg::s_rd1) src1_r <= core_rdata;
    if (state == core_pkg::s_exec && alu_state == core_pkg::alu_results) begin
      res_lo <= alu_dst;
      res_hi <= alu_dst_h;
    end
  end

endmodule

`default_nettype wire

/* exec_core.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_core (
  input  wire                clk,
  input  wire                rst,
  // command side
  input  core_pkg::cmd_t     cmd,
  input  wire                cmd_valid,
  output logic               busy,
  output logic               cmd_done,
  // host side
  input  wire                host_rd,
  input  wire                host_wr,
  input  mem_pkg::addr_t     host_addr,
  input  core_pkg::data_t    host_wdata,
  output core_pkg::data_t    host_rdata,
  output logic               host_rvalid
);

  // sequencer <-> arbiter
  logic core_req;
  logic core_we;
  logic core_gnt;
  logic core_rvalid;
  mem_pkg::addr_t core_addr;
  core_pkg::data_t core_wdata;
  core_pkg::data_t core_rdata;
  // sequencer <-> alu
  core_pkg::alu_state_t alu_state;
  core_pkg::op_code_t alu_op;
  core_pkg::data_t alu_src0;
  core_pkg::data_t alu_src1;
  core_pkg::data_t alu_dst;
  core_pkg::data_t alu_dst_h;
  logic alu_next;
  // arbiter <-> ram
  logic ram_we;
  mem_pkg::addr_t ram_addr;
  core_pkg::data_t ram_wdata;
  core_pkg::data_t ram_rdata;

  cmd_sequencer seq_inst (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .busy        (busy),
    .cmd_done    (cmd_done),
    .core_req    (core_req),
    .core_we     (core_we),
    .core_addr   (core_addr),
    .core_wdata  (core_wdata),
    .core_gnt    (core_gnt),
    .core_rvalid (core_rvalid),
    .core_rdata  (core_rdata),
    .alu_state   (alu_state),
    .alu_op      (alu_op),
    .alu_src0    (alu_src0),
    .alu_src1    (alu_src1),
    .alu_next    (alu_next),
    .alu_dst     (alu_dst),
    .alu_dst_h   (alu_dst_h)
  );

  alu alu_inst (
    .clk        (clk),
    .rst        (rst),
    .state      (alu_state),
    .op         (alu_op),
    .src0       (alu_src0),
    .src1       (alu_src1),
    .dst        (alu_dst),
    .dst_h      (alu_dst_h),
    .next_state (alu_next)
  );

  mem_arbiter arb_inst (
    .clk         (clk),
    .rst         (rst),
    .host_rd     (host_rd),
    .host_wr     (host_wr),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .core_req    (core_req),
    .core_we     (core_we),
    .core_addr   (core_addr),
    .core_wdata  (core_wdata),
    .core_gnt    (core_gnt),
    .core_rdata  (core_rdata),
    .core_rvalid (core_rvalid),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ram_rdata   (ram_rdata)
  );

  data_ram ram_inst (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

`default_nettype wire

/* tb_exec_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_core;

  localparam int clk_half = 20;       // 40 ns period
  localparam int n_fill_reads = 64;
  localparam int n_arith = 20;
  localparam int n_logic = 30;
  localparam int n_div = 12;
  localparam int n_busy = 6;
  localparam int n_busy_host = 8;     // host ops per busy command, at most
  localparam int num_cmds = n_arith + n_logic + n_div + n_busy + 4;
  localparam int host_ops = mem_pkg::mem_depth + 2 * n_fill_reads + 2 * n_arith
                            + 4 * n_logic + 4 * n_div + n_busy * (n_busy_host + 2) + 4;
  localparam int timeout_ns = (num_cmds * 60 + host_ops) * 2 * clk_half;
  localparam int done_limit = 200;    // cycles before a command counts as stuck

  logic clk;
  logic rst;
  core_pkg::cmd_t cmd;
  logic cmd_valid;
  logic busy;
  logic cmd_done;
  logic host_rd;
  logic host_wr;
  mem_pkg::addr_t host_addr;
  core_pkg::data_t host_wdata;
  core_pkg::data_t host_rdata;
  logic host_rvalid;

  core_pkg::data_t model [mem_pkg::mem_depth]; // mirror of the ram
  int errs = 0;
  int test_errs = 0;
  int tests_failed = 0;
  int checks = 0;
  int done_count = 0;  // cmd_done pulses seen so far

  exec_core exec_core_inst (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .busy        (busy),
    .cmd_done    (cmd_done),
    .host_rd     (host_rd),
    .host_wr     (host_wr),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid)
  );

  always #clk_half clk = ~clk;

  // cmd_done depends on host strobes, so look just after the falling edge drive
  always @(negedge clk) begin
    #1;
    if (cmd_done === 1'b1) done_count++;
  end

  initial begin
    #(timeout_ns);
    $display("timeout: run did not finish within %0d ns", timeout_ns);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_val(input string name, input core_pkg::data_t exp,
                           input core_pkg::data_t act);
    checks++;
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("error: %s", what);
      test_errs++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s finished, %0d errors", num, name, test_errs);
    if (test_errs != 0) tests_failed++;
    errs += test_errs;
    test_errs = 0;
  endtask

  // called on a falling edge, returns on one
  task automatic write_word(input mem_pkg::addr_t addr, input core_pkg::data_t data);
    host_wr = 1'b1;
    host_addr = addr;
    host_wdata = data;
    @(negedge clk);
    host_wr = 1'b0;
    model[addr] = data; // ram updated at that edge
  endtask

  task automatic read_word(input string name, input mem_pkg::addr_t addr);
    host_rd = 1'b1;
    host_addr = addr;
    @(negedge clk);
    host_rd = 1'b0;
    check_true(host_rvalid, "host_rvalid missing one cycle after host_rd");
    check_val(name, model[addr], host_rdata);
  endtask

  function automatic core_pkg::cmd_t make_cmd(input core_pkg::op_code_t op,
                                              input mem_pkg::addr_t dst, s0, s1);
    return {op, dst, s0, s1, 4'h0};
  endfunction

  // {high, low} result from the op rules
  function automatic logic [63:0] expected_result(input core_pkg::op_code_t op,
                                                  input core_pkg::data_t a, b);
    logic [63:0] r;
    case (op)
      core_pkg::op_mov: r = {32'h0, a};
      core_pkg::op_add: r = {((a + b) < a) ? 32'h1 : 32'h0, a + b}; // carry when sum wraps
      core_pkg::op_sub: r = {(a < b) ? 32'hffff_ffff : 32'h0, a - b};
      core_pkg::op_mul: r = {32'h0, a} * {32'h0, b};
      core_pkg::op_div: r = (b == 0) ? {a, 32'hffff_ffff} : {a % b, a / b};
      core_pkg::op_shr: r = (b >= 32) ? 64'h0 : {32'h0, a >> b};
      core_pkg::op_shl: r = (b >= 32) ? 64'h0 : {32'h0, a << b};
      core_pkg::op_xor: r = {32'h0, a ^ b};
      core_pkg::op_and: r = {32'h0, a & b};
      core_pkg::op_or: r = {32'h0, a | b};
      default: r = 64'h0;  // codes 10..15
    endcase
    return r;
  endfunction

  // random address clear of a command's footprint
  function automatic mem_pkg::addr_t free_addr(input mem_pkg::addr_t dst, s0, s1);
    mem_pkg::addr_t a;
    a = mem_pkg::addr_t'($urandom);
    while (a == dst || a == mem_pkg::addr_t'(dst + 1) || a == s0 || a == s1) begin
      a = mem_pkg::addr_t'($urandom);
    end
    return a;
  endfunction

  task automatic issue_cmd(input core_pkg::cmd_t c);
    cmd = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    check_true(busy, "busy did not rise after the command was accepted");
  endtask

  task automatic wait_cmd_done(input int start);
    int n;
    n = 0;
    while (done_count == start && n < done_limit) begin
      @(negedge clk);
      n++;
    end
    check_true(done_count != start, "command never pulsed cmd_done");
    check_true(!busy, "busy still high the cycle after cmd_done");
  endtask

  task automatic run_cmd(input string name, input core_pkg::op_code_t op,
                         input mem_pkg::addr_t dst, s0, s1);
    logic [63:0] res;
    mem_pkg::addr_t dst_hi;
    int start;
    res = expected_result(op, model[s0], model[s1]); // sources read before writes
    dst_hi = dst + mem_pkg::addr_t'(1);              // wraps 255 -> 0
    start = done_count;
    issue_cmd(make_cmd(op, dst, s0, s1));
    wait_cmd_done(start);
    model[dst] = res[31:0];
    model[dst_hi] = res[63:32];
    read_word({name, " lo"}, dst);
    read_word({name, " hi"}, dst_hi);
  endtask

  initial begin
    int i;
    int k;
    int n;
    int start;
    int seed_val;
    core_pkg::op_code_t op;
    mem_pkg::addr_t dst;
    mem_pkg::addr_t s0;
    mem_pkg::addr_t s1;
    mem_pkg::addr_t a;
    logic [63:0] res;
    core_pkg::data_t val;

    seed_val = $urandom(26816);
    clk = 1'b0;
    rst = 1'b1;
    cmd = '0;
    cmd_valid = 1'b0;
    host_rd = 1'b0;
    host_wr = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // 1: reset state, fill and read back
    check_true(!busy, "busy high after reset");
    check_true(!cmd_done, "cmd_done high after reset");
    check_true(!host_rvalid, "host_rvalid high after reset");
    for (i = 0; i < mem_pkg::mem_depth; i++) write_word(mem_pkg::addr_t'(i), $urandom);
    for (i = 0; i < n_fill_reads; i++) begin
      read_word("fill read", mem_pkg::addr_t'($urandom));
      @(negedge clk);
      check_true(!host_rvalid, "host_rvalid high for more than one cycle");
    end
    end_test(1, "host fill and read");

    // 2: add / sub / mul, first one wraps its high word to 0
    for (i = 0; i < n_arith; i++) begin
      op = core_pkg::op_code_t'(1 + $urandom % 3);
      dst = (i == 0) ? 8'd255 : mem_pkg::addr_t'($urandom);
      run_cmd("arith", op, dst, mem_pkg::addr_t'($urandom), mem_pkg::addr_t'($urandom));
    end
    end_test(2, "add sub mul");

    // 3: mov, shifts, logic and undefined codes
    for (i = 0; i < n_logic; i++) begin
      k = $urandom % 12;
      op = (k == 0) ? core_pkg::op_mov : core_pkg::op_code_t'(k + 4); // 5..15
      s0 = mem_pkg::addr_t'($urandom);
      s1 = s0 + mem_pkg::addr_t'(1 + $urandom % 255);                // never s0
      k = $urandom % 4;
      if (k == 0) val = 32 + $urandom % 8;    // shifts out everything
      else if (k == 1) val = $urandom;
      else val = $urandom % 32;
      write_word(s0, $urandom);
      write_word(s1, val);
      run_cmd("logic", op, mem_pkg::addr_t'($urandom), s0, s1);
    end
    end_test(3, "mov shift logic undefined");

    // 4: divide, about a third by zero
    for (i = 0; i < n_div; i++) begin
      s0 = mem_pkg::addr_t'($urandom);
      s1 = s0 + mem_pkg::addr_t'(1 + $urandom % 255);
      k = $urandom % 3;
      if (k == 0) val = '0;
      else if (k == 1) val = 1 + $urandom % 1000;
      else val = $urandom;
      write_word(s0, $urandom);
      write_word(s1, val);
      run_cmd("div", core_pkg::op_div, mem_pkg::addr_t'($urandom), s0, s1);
    end
    end_test(4, "divide");

    // 5: host traffic elsewhere while the core runs
    for (i = 0; i < n_busy; i++) begin
      op = core_pkg::op_code_t'($urandom % 10);
      dst = mem_pkg::addr_t'($urandom);
      s0 = mem_pkg::addr_t'($urandom);
      s1 = mem_pkg::addr_t'($urandom);
      res = expected_result(op, model[s0], model[s1]);
      start = done_count;
      issue_cmd(make_cmd(op, dst, s0, s1));
      fork
        wait_cmd_done(start);
        begin
          n = 0;
          while (busy && n < n_busy_host) begin
            a = free_addr(dst, s0, s1);
            if ($urandom % 2) write_word(a, $urandom);
            else read_word("busy host read", a);
            n++;
          end
        end
      join
      model[dst] = res[31:0];
      model[mem_pkg::addr_t'(dst + 1)] = res[63:32];
      read_word("busy cmd lo", dst);
      read_word("busy cmd hi", mem_pkg::addr_t'(dst + 1));
    end
    end_test(5, "host traffic while busy");

    // 6: second command strobed while busy must be dropped
    s0 = mem_pkg::addr_t'($urandom);  // s0, s1, dst pair, then the ignored pair
    s1 = s0 + mem_pkg::addr_t'(1);
    dst = s0 + mem_pkg::addr_t'(2);
    a = s0 + mem_pkg::addr_t'(4);
    res = expected_result(core_pkg::op_mul, model[s0], model[s1]);
    start = done_count;
    issue_cmd(make_cmd(core_pkg::op_mul, dst, s0, s1));
    for (k = 0; k < 3; k++) begin
      if (busy) begin
        cmd = make_cmd(core_pkg::op_add, a, s0, s1);
        cmd_valid = 1'b1;
      end
      @(negedge clk);
      cmd_valid = 1'b0;
      @(negedge clk);
    end
    wait_cmd_done(start);
    model[dst] = res[31:0];
    model[mem_pkg::addr_t'(dst + 1)] = res[63:32];
    repeat (60) @(negedge clk); // room for a wrongly accepted command to finish
    check_true(done_count == start + 1, "cmd_done count wrong, a busy strobe was taken");
    check_true(!busy, "core busy again after the first command");
    read_word("first cmd lo", dst);
    read_word("first cmd hi", mem_pkg::addr_t'(dst + 1));
    read_word("ignored cmd lo", a);
    read_word("ignored cmd hi", mem_pkg::addr_t'(a + 1));
    end_test(6, "strobe while busy");

    $display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errs);
    if (errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
core_pkg.sv
mem_pkg.sv
data_ram.sv
mem_arbiter.sv
serial_divider.sv
alu.sv
cmd_sequencer.sv
exec_core.sv
tb_exec_core.sv
